// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := videoPipeTb
FILELIST  := project.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

// File: hdl/apbHostPort.sv
// APB slave with control and status registers and pixel access to the frame store
`default_nettype none

module apbHostPort
    import videoTimingPkg::*;
    import hostBusPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [apbAddrBits-1:0] paddr,
    input  logic [apbDataBits-1:0] pwdata,
    output logic [apbDataBits-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   fe,
    frameMemIf.requester           mem,
    output logic                   enable,
    output logic [pixelBits-1:0]   background
);

    logic       accessPhase;
    logic       isCtrl;
    logic       isStatus;
    logic       isPixel;
    logic       isUnmapped;
    // Read granted, data due this cycle
    logic       readWait;
    ctrlWord_t  ctrlReg;
    logic [15:0] frameCount;
    apbWord_u   wordIn;

    // --------------------
    // Address decode
    // --------------------
    assign accessPhase = psel && penable;
    assign isCtrl      = (paddr == ctrlAddr);
    assign isStatus    = (paddr == statusAddr);
    assign isPixel     = (paddr >= pixelBase);
    assign isUnmapped  = !(isCtrl || isStatus || isPixel);
    assign wordIn      = pwdata;

    // Frame store request, word index from byte address
    assign mem.req   = accessPhase && isPixel && !readWait;
    assign mem.we    = pwrite;
    assign mem.addr  = paddr[pixelAddrBits+1:2];
    assign mem.wdata = {wordIn.pixel.red, wordIn.pixel.green, wordIn.pixel.blue};

    // --------------------
    // Response
    // --------------------
    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        prdata  = '0;
        if (accessPhase) begin
            if (isPixel) begin
                // Write done at grant, read one cycle later
                pready = readWait || (mem.gnt && pwrite);
                prdata = {8'h00, mem.rdata};
            end else begin
                pready  = 1'b1;
                pslverr = isUnmapped;
                if (isCtrl) begin
                    prdata = ctrlReg;
                end else if (isStatus) begin
                    prdata = {16'h0000, frameCount};
                end
            end
        end
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            readWait   <= 1'b0;
            ctrlReg    <= '0;
            frameCount <= '0;
        end else begin
            readWait <= mem.req && mem.gnt && !pwrite;
            if (accessPhase && pwrite && isCtrl) begin
                ctrlReg <= wordIn.ctrl;
            end
            // Wraps at 16 bits
            if (fe) begin
                frameCount <= frameCount + 1'b1;
            end
        end
    end

    assign enable     = ctrlReg.enable;
    assign background = ctrlReg.background;

endmodule

`default_nettype wire

// File: hdl/displayTiming.sv
// Horizontal and vertical counters with registered video timing strobes
`default_nettype none

module displayTiming import videoTimingPkg::*; (
    input  logic clk,
    input  logic rst,
    output logic vde,
    output logic fvde,
    output logic fe,
    output logic hsync,
    output logic vsync
);

    logic [hCountBits-1:0] hCount;
    logic [hCountBits-1:0] hNext;
    logic [vCountBits-1:0] vCount;
    logic [vCountBits-1:0] vNext;

    // --------------------
    // Next counter position
    // --------------------
    always_comb begin
        hNext = hCount + 1'b1;
        vNext = vCount;
        // End of line wraps h and steps v
        if (hCount == hCountBits'(hTotal - 1)) begin
            hNext = '0;
            if (vCount == vCountBits'(vTotal - 1)) begin
                vNext = '0;
            end else begin
                vNext = vCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            hCount <= hNext;
            vCount <= vNext;
        end
    end

    // --------------------
    // Strobes
    // --------------------
    // Decoded from the next position so each flop lines up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            vde   <= 1'b0;
            fvde  <= 1'b0;
            fe    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            // Active area
            vde  <= (hNext < hCountBits'(hDisplay)) && (vNext < vCountBits'(vDisplay));
            fvde <= (vNext < vCountBits'(vDisplay));
            // Last counter position of the frame
            fe   <= (hNext == hCountBits'(hTotal - 1)) && (vNext == vCountBits'(vTotal - 1));
            // Line sync after the front porch
            hsync <= (hNext >= hCountBits'(hDisplay + hFront))
                  && (hNext < hCountBits'(hDisplay + hFront + hSync));
            // Whole sync lines after the bottom border
            vsync <= (vNext >= vCountBits'(vDisplay + vBottom))
                  && (vNext < vCountBits'(vDisplay + vBottom + vSync));
        end
    end

endmodule

`default_nettype wire

// File: hdl/frameMemIf.sv
// Request and grant interface between a requester and the frame store
`default_nettype none

interface frameMemIf import videoTimingPkg::*; ();

    // Request side, held stable until gnt
    logic                     req;
    logic                     we;
    logic [pixelAddrBits-1:0] addr;
    logic [pixelBits-1:0]     wdata;

    // Store side
    // gnt completes the access in its cycle
    logic                     gnt;
    // Valid one cycle after a read grant
    logic [pixelBits-1:0]     rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport store (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

`default_nettype wire

// File: hdl/frameStore.sv
// Fixed-priority arbiter in front of a single-port pixel RAM
`default_nettype none

module frameStore import videoTimingPkg::*; (
    input  logic clk,
    frameMemIf.store scan,
    frameMemIf.store host
);

    // One frame, raster order
    logic [pixelBits-1:0]     ram [pixelWords];
    logic [pixelAddrBits-1:0] ramAddr;
    logic [pixelBits-1:0]     rdataQ;

    // --------------------
    // Arbiter
    // --------------------
    // Scan-out always wins, host waits
    always_comb begin
        scan.gnt = scan.req;
        host.gnt = host.req && !scan.req;
        if (scan.req) begin
            ramAddr = scan.addr;
        end else begin
            ramAddr = host.addr;
        end
    end

    // --------------------
    // RAM
    // --------------------
    // Only the host writes
    always_ff @(posedge clk) begin
        if (host.gnt && host.we) begin
            ram[ramAddr] <= host.wdata;
        end
        // Old data on a write cycle
        rdataQ <= ram[ramAddr];
    end

    // Shared return path, each side samples after its own grant
    assign scan.rdata = rdataQ;
    assign host.rdata = rdataQ;

endmodule

`default_nettype wire

// File: hdl/hostBusPkg.sv
// APB address map and the control and pixel views of the data word
`default_nettype none

package hostBusPkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int apbAddrBits = 10;
    localparam int apbDataBits = 32;

    // --------------------
    // Register map, byte offsets
    // --------------------
    localparam logic [apbAddrBits-1:0] ctrlAddr = 10'h000;
    localparam logic [apbAddrBits-1:0] statusAddr = 10'h004;
    // 128 pixel words, 0x200 up to 0x3FC
    localparam logic [apbAddrBits-1:0] pixelBase = 10'h200;

    // Control register layout
    typedef struct packed {
        logic        enable;
        logic [6:0]  reserved;
        logic [23:0] background;
    } ctrlWord_t;

    // Pixel word, RGB in the low three bytes
    typedef struct packed {
        logic [7:0] reserved;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixelWord_t;

    // Same pwdata bits, meaning chosen by address
    typedef union packed {
        ctrlWord_t  ctrl;
        pixelWord_t pixel;
    } apbWord_u;

endpackage

`default_nettype wire

// File: hdl/scanoutFetch.sv
// Raster address counter, frame store read and two-stage pixel output pipeline
`default_nettype none

module scanoutFetch import videoTimingPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vde,
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 fe,
    input  logic                 enable,
    input  logic [pixelBits-1:0] background,
    frameMemIf.requester         mem,
    output logic [pixelBits-1:0] pixel,
    output logic                 vdeOut,
    output logic                 hsyncOut,
    output logic                 vsyncOut,
    output logic                 feOut
);

    logic [pixelAddrBits-1:0] rasterAddr;
    // Timing bits {vde, hsync, vsync, fe} per stage
    logic [3:0] syncD1;
    logic [3:0] syncD2;
    // Stage 1 pixel comes from memory
    logic       fetchD1;

    // Raster index, steps on every active pixel
    always_ff @(posedge clk) begin
        if (rst || fe) begin
            rasterAddr <= '0;
        end else if (vde) begin
            rasterAddr <= rasterAddr + 1'b1;
        end
    end

    // --------------------
    // Memory read
    // --------------------
    // Read only, priority grant lands in the same cycle
    assign mem.req   = vde && enable;
    assign mem.we    = 1'b0;
    assign mem.addr  = rasterAddr;
    assign mem.wdata = '0;

    // --------------------
    // Output pipeline
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            syncD1  <= '0;
            syncD2  <= '0;
            fetchD1 <= 1'b0;
            pixel   <= '0;
        end else begin
            syncD1  <= {vde, hsync, vsync, fe};
            syncD2  <= syncD1;
            fetchD1 <= mem.req && mem.gnt;
            // Black outside active video
            if (!syncD1[3]) begin
                pixel <= '0;
            end else if (fetchD1) begin
                pixel <= mem.rdata;
            end else begin
                pixel <= background;
            end
        end
    end

    assign {vdeOut, hsyncOut, vsyncOut, feOut} = syncD2;

endmodule

`default_nettype wire

// File: hdl/videoPipeTop.sv
// Display pipeline top with timing, APB host port, scan-out and frame store
`default_nettype none

module videoPipeTop
    import videoTimingPkg::*;
    import hostBusPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [apbAddrBits-1:0] paddr,
    input  logic [apbDataBits-1:0] pwdata,
    output logic [apbDataBits-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    // Video out, two cycles behind the counters
    output logic [pixelBits-1:0]   pixel,
    output logic                   vde,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   fe
);

    // --------------------
    // Timing strobes
    // --------------------
    logic tVde;
    logic tFe;
    logic tHsync;
    logic tVsync;
    // Control register fields
    logic                 enable;
    logic [pixelBits-1:0] background;

    frameMemIf scanMem ();
    frameMemIf hostMem ();

    displayTiming timing0 (
        .clk   (clk),
        .rst   (rst),
        .vde   (tVde),
        .fvde  (),
        .fe    (tFe),
        .hsync (tHsync),
        .vsync (tVsync)
    );

    apbHostPort hostPort0 (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fe         (tFe),
        .mem        (hostMem.requester),
        .enable     (enable),
        .background (background)
    );

    scanoutFetch scanout0 (
        .clk        (clk),
        .rst        (rst),
        .vde        (tVde),
        .hsync      (tHsync),
        .vsync      (tVsync),
        .fe         (tFe),
        .enable     (enable),
        .background (background),
        .mem        (scanMem.requester),
        .pixel      (pixel),
        .vdeOut     (vde),
        .hsyncOut   (hsync),
        .vsyncOut   (vsync),
        .feOut      (fe)
    );

    // Scan-out on the priority port
    frameStore store0 (
        .clk  (clk),
        .scan (scanMem.store),
        .host (hostMem.store)
    );

endmodule

`default_nettype wire

// File: hdl/videoTimingPkg.sv
// Display mode timing, counter widths and frame geometry
`default_nettype none

package videoTimingPkg;

    // --------------------
    // Horizontal timing in pixel clocks
    // --------------------
    localparam int hDisplay = 16;
    localparam int hFront = 2;
    localparam int hSync = 3;
    localparam int hBack = 3;
    localparam int hTotal = hDisplay + hFront + hSync + hBack;

    // --------------------
    // Vertical timing in lines
    // --------------------
    localparam int vDisplay = 8;
    localparam int vBottom = 1;
    localparam int vSync = 2;
    localparam int vTop = 1;
    localparam int vTotal = vDisplay + vBottom + vSync + vTop;

    // Whole frame in clock cycles
    localparam int frameCycles = hTotal * vTotal;

    // Counter widths, 0..23 and 0..11
    localparam int hCountBits = 5;
    localparam int vCountBits = 4;

    // Frame store geometry, raster-order index
    localparam int pixelWords = hDisplay * vDisplay;
    localparam int pixelAddrBits = 7;
    localparam int pixelBits = 24;

endpackage

`default_nettype wire

// File: project.f
hdl/videoTimingPkg.sv
hdl/hostBusPkg.sv
hdl/frameMemIf.sv
hdl/displayTiming.sv
hdl/apbHostPort.sv
hdl/scanoutFetch.sv
hdl/frameStore.sv
hdl/videoPipeTop.sv
tb/videoPipe_checker.sv
tb/videoPipeTb.sv

// File: tb/videoPipeTb.sv
// Display pipeline testbench with clock, reset, stimulus reader, frame model, checks and report
`default_nettype none

module videoPipeTb import videoTimingPkg::*, hostBusPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 20;
    localparam int resetCycles = 10;
    localparam logic [31:0] rngSeed = 32'h2b18;
    localparam string stimPath = "tb/videoPipe_stim.txt";

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [apbAddrBits-1:0] paddr;
    logic [apbDataBits-1:0] pwdata;
    logic [apbDataBits-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic [pixelBits-1:0]   pixel;
    logic                   vde;
    logic                   hsync;
    logic                   vsync;
    logic                   fe;

    // Stimulus columns with one entry per file line
    logic [7:0]             stimOp [$];
    logic [apbAddrBits-1:0] stimAddr [$];
    logic [31:0]            stimData [$];
    logic                   stimErr [$];
    logic                   stimLoaded;

    // Reference frame, last control word, counters
    logic [pixelBits-1:0] frameModel [pixelWords];
    logic [31:0]          ctrlShadow;
    logic [31:0]          rngState;
    int                   feCount;
    int                   errorCount;
    int                   checkCount;
    int                   testCount;
    int                   failedTests;

    videoPipeTop dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pixel   (pixel),
        .vde     (vde),
        .hsync   (hsync),
        .vsync   (vsync),
        .fe      (fe)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Frame ends seen at the video ports
    always @(negedge clk) begin
        if (fe) begin
            feCount++;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // One APB transfer with the access phase held until pready
    task automatic apbAccess(input logic write, input logic [apbAddrBits-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        // Back-pressure while scan-out owns the store
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic waitFrameEnd();
        @(negedge clk);
        while (!fe) begin
            @(negedge clk);
        end
    endtask

    task automatic loadStimulus(output logic ok);
        int                     fd;
        int                     count;
        logic [7:0]             op;
        logic [apbAddrBits-1:0] addr;
        logic [31:0]            data;
        logic                   err;
        logic [8*128-1:0]       rest;
        ok = 1'b0;
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            return;
        end
        ok = 1'b1;
        while (!$feof(fd)) begin
            count = $fscanf(fd, "%s", op);
            if (count != 1) begin
                break;
            end
            if (op == "#") begin
                count = $fgets(rest, fd);
            end else begin
                count = $fscanf(fd, "%h %h %h", addr, data, err);
                if (count != 3) begin
                    $display("Stimulus line for operation %c has missing columns", op);
                    ok = 1'b0;
                end
                stimOp.push_back(op);
                stimAddr.push_back(addr);
                stimData.push_back(data);
                stimErr.push_back(err);
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic checkReset();
        int errorsBefore;
        errorsBefore = errorCount;
        // rst sampled high on ten rising edges
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            if (i == resetCycles - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            checkValue("reset outputs", 32'd0, 32'({vde, hsync, vsync, fe, pready, pslverr}));
        end
        // Ports still quiet as video lags the counters
        @(negedge clk);
        checkValue("after reset outputs", 32'd0, 32'({vde, hsync, vsync, fe, pready, pslverr}));
        reportTest("reset state", errorsBefore);
    endtask

    // All 128 words from the xorshift sequence
    task automatic fillFrame(input string name);
        logic [31:0]            rdata;
        logic                   err;
        logic [apbAddrBits-1:0] addr;
        for (int i = 0; i < pixelWords; i++) begin
            rngState = nextRandom(rngState);
            addr = apbAddrBits'(int'(pixelBase) + 4 * i);
            apbAccess(1'b1, addr, rngState, rdata, err);
            checkValue({name, " pslverr"}, 32'd0, 32'(err));
            frameModel[i] = rngState[pixelBits-1:0];
        end
    endtask

    // Two whole frames with the index restarting after each frame end
    task automatic scanoutCheck(input string name, input logic useBackground);
        int                   idx;
        int                   frames;
        int                   hPos;
        int                   vPos;
        logic [pixelBits-1:0] expected;
        logic [3:0]           timingExp;
        waitFrameEnd();
        idx = 0;
        frames = 0;
        // First cycle after a frame end is the top left position
        hPos = 0;
        vPos = 0;
        while (frames < 2) begin
            @(negedge clk);
            // Strobes at this raster position as vde hsync vsync fe
            timingExp[3] = (hPos < hDisplay) && (vPos < vDisplay);
            timingExp[2] = (hPos >= hDisplay + hFront) && (hPos < hDisplay + hFront + hSync);
            timingExp[1] = (vPos >= vDisplay + vBottom) && (vPos < vDisplay + vBottom + vSync);
            timingExp[0] = (hPos == hTotal - 1) && (vPos == vTotal - 1);
            checkValue({name, " timing"}, 32'(timingExp), 32'({vde, hsync, vsync, fe}));
            if (vde) begin
                if (useBackground) begin
                    expected = ctrlShadow[pixelBits-1:0];
                end else begin
                    expected = frameModel[idx[pixelAddrBits-1:0]];
                end
                checkValue(name, 32'(expected), 32'(pixel));
                idx++;
            end
            if (fe) begin
                checkValue({name, " active pixels"}, pixelWords, idx);
                idx = 0;
                frames++;
            end
            // Step along the line, then down the frame
            if (hPos == hTotal - 1) begin
                hPos = 0;
                vPos = (vPos == vTotal - 1) ? 0 : vPos + 1;
            end else begin
                hPos++;
            end
        end
    endtask

    task automatic runOperation(input int n);
        logic [31:0] rdata;
        logic        err;
        int          errorsBefore;
        int          pixelIdx;
        string       name;
        errorsBefore = errorCount;
        name = $sformatf("op %c at %03h", stimOp[n], stimAddr[n]);
        case (stimOp[n])
            "W": begin
                apbAccess(1'b1, stimAddr[n], stimData[n], rdata, err);
                checkValue({name, " pslverr"}, 32'(stimErr[n]), 32'(err));
                if (!stimErr[n] && stimAddr[n] == ctrlAddr) begin
                    ctrlShadow = stimData[n];
                end
            end
            "R": begin
                apbAccess(1'b0, stimAddr[n], 32'd0, rdata, err);
                checkValue(name, stimData[n], rdata);
                checkValue({name, " pslverr"}, 32'(stimErr[n]), 32'(err));
            end
            "P": begin
                apbAccess(1'b0, stimAddr[n], 32'd0, rdata, err);
                // Word offset from the start of the pixel window
                pixelIdx = (int'(stimAddr[n]) - int'(pixelBase)) / 4;
                checkValue(name, {8'h00, frameModel[pixelIdx]}, rdata);
                checkValue({name, " pslverr"}, 32'(stimErr[n]), 32'(err));
            end
            "S": begin
                // Read well clear of the next frame end
                waitFrameEnd();
                apbAccess(1'b0, stimAddr[n], 32'd0, rdata, err);
                checkValue(name, {16'h0000, feCount[15:0]}, rdata);
                checkValue({name, " pslverr"}, 32'(stimErr[n]), 32'(err));
            end
            "F": fillFrame(name);
            "E": scanoutCheck(name, 1'b0);
            "B": scanoutCheck(name, 1'b1);
            default: begin
                $display("Unknown operation %c in the stimulus file", stimOp[n]);
                errorCount++;
            end
        endcase
        reportTest(name, errorsBefore);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic ok;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        stimLoaded = 1'b0;
        feCount = 0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        failedTests = 0;
        ctrlShadow = '0;
        rngState = rngSeed;
        loadStimulus(ok);
        if (!ok) begin
            $display("Could not read the stimulus file %s", stimPath);
            errorCount++;
        end else begin
            stimLoaded = 1'b1;
            checkReset();
            for (int n = 0; n < stimOp.size(); n++) begin
                runOperation(n);
            end
        end
        if (dut0.checker0.failCount != 0) begin
            $display("Checker assertions failed %0d times", dut0.checker0.failCount);
            errorCount += dut0.checker0.failCount;
        end
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Eight frames plus a few frames per stimulus line
    initial begin
        int limitCycles;
        wait (stimLoaded);
        limitCycles = (8 + 4 * stimOp.size()) * frameCycles;
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limitCycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/videoPipe_checker.sv
// APB handshake and video output assertions bound into the pipeline top
`default_nettype none

module videoPipeChecker import videoTimingPkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 pslverr,
    input logic                 hsync,
    input logic                 vde,
    input logic [pixelBits-1:0] pixel
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of assertion failures so far
    int failCount = 0;

    // --------------------
    // APB
    // --------------------
    assert property (@(posedge clk) disable iff (rst) pready |-> (psel && penable))
        else begin
            failCount++;
            $error("pready raised outside an APB access phase");
        end

    assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
        else begin
            failCount++;
            $error("pslverr raised without pready");
        end

    // --------------------
    // Video
    // --------------------
    // Pulse was high exactly hSync samples before it fell
    assert property (@(posedge clk) disable iff (rst)
        $fell(hsync) |-> ($past(hsync, hSync) && !$past(hsync, hSync + 1)))
        else begin
            failCount++;
            $error("hsync pulse length differs from the mode timing");
        end

    // Black outside active video
    assert property (@(posedge clk) disable iff (rst) !vde |-> (pixel == '0))
        else begin
            failCount++;
            $error("pixel not zero while vde is low");
        end

endmodule

bind videoPipeTop videoPipeChecker checker0 (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .hsync   (hsync),
    .vde     (vde),
    .pixel   (pixel)
);

`default_nettype wire

// File: tb/videoPipe_stim.txt
# op addr data err: W write, R read and compare data, P pixel read against model
# F fill frame, S status against counted frames, E scan-out frame, B background
W 000 80123456 0
R 000 80123456 0
S 004 00000000 0
F 200 00000000 0
P 200 00000000 0
P 204 00000000 0
P 2a8 00000000 0
P 3fc 00000000 0
S 004 00000000 0
E 000 00000000 0
W 000 00a5c3e1 0
B 000 00000000 0
W 100 deadbeef 1
R 100 00000000 1
R 000 00a5c3e1 0
S 004 00000000 0
